/* cache_bank.f */
cache_pkg.sv
cache_sp_ram.sv
cache_tags.sv
cache_data.sv
cache_bank.sv
cache_bank_checker.sv
cache_bank_tb.sv

/* Makefile */
SRCS := $(shell cat cache_bank.f)

.PHONY: run clean

obj_dir/Vcache_bank_tb: cache_bank.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module cache_bank_tb \
		-f cache_bank.f -Mdir obj_dir

run: obj_dir/Vcache_bank_tb
	./obj_dir/Vcache_bank_tb | tee sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* cache_bank_tb.sv */
`timescale 1ns/1ns

module cache_bank_tb;
    import cache_pkg::*;

    localparam int NUM_WAYS     = 2;
    localparam int NUM_SETS     = 8;
    localparam int LINE_WORDS   = 4;
    localparam int WORD_BYTES   = 4;
    localparam int WORD_WIDTH   = WORD_BYTES * BYTE_WIDTH;
    localparam int NUM_REQS     = 600;
    localparam int RESET_CYCLES = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int LIMIT_CYCLES = NUM_REQS * 30 + RESET_CYCLES;

    // Three tags over all sets, more lines than the cache holds
    localparam logic [ADDR_WIDTH-1:0] POOL_BASE [3] = '{
        32'h0040_0000, 32'h1234_5600, 32'h8000_0F80
    };

    logic                             clk;
    logic                             rst_n;
    logic                             req_valid;
    req_op_t                          req_op;
    logic [ADDR_WIDTH-1:0]            req_addr;
    logic [WORD_BYTES-1:0]            req_byteen;
    logic [WORD_WIDTH-1:0]            req_data;
    logic                             busy;
    logic                             rsp_valid;
    logic [WORD_WIDTH-1:0]            rsp_data;
    logic                             mem_rd_valid;
    logic [ADDR_WIDTH-1:0]            mem_rd_addr;
    logic                             mem_fill_valid;
    logic [LINE_WORDS*WORD_WIDTH-1:0] mem_fill_data;
    logic                             mem_wr_valid;
    logic [ADDR_WIDTH-1:0]            mem_wr_addr;
    logic [WORD_BYTES-1:0]            mem_wr_byteen;
    logic [WORD_WIDTH-1:0]            mem_wr_data;

    integer                seed = 78;
    int                    errors;
    int                    reads = 0;
    int                    writes = 0;
    logic                  drained;
    logic [WORD_WIDTH-1:0] mem_img [logic [ADDR_WIDTH-1:0]];

    cache_bank #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_WORDS (LINE_WORDS),
        .WORD_BYTES (WORD_BYTES)
    ) UUT (.*);

    cache_bank_checker #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_WORDS (LINE_WORDS),
        .WORD_BYTES (WORD_BYTES)
    ) scoreboard (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [WORD_WIDTH-1:0] memory_word(logic [ADDR_WIDTH-1:0] addr);
        if (mem_img.exists(addr)) begin
            return mem_img[addr];
        end
        return WORD_WIDTH'((addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]});
    endfunction

    task automatic drive_request();
        req_valid  = 1'b1;
        req_op     = (($unsigned($random(seed)) % 100) < 60) ? OP_READ : OP_WRITE;
        req_addr   = POOL_BASE[$unsigned($random(seed)) % 3] |
                     ADDR_WIDTH'(($unsigned($random(seed)) % (NUM_SETS * LINE_WORDS)) * WORD_BYTES);
        req_byteen = WORD_BYTES'(1 + ($unsigned($random(seed)) % ((1 << WORD_BYTES) - 1)));
        req_data   = WORD_WIDTH'($random(seed));
        if (req_op == OP_READ) begin
            reads++;
        end else begin
            writes++;
        end
    endtask

    // Memory takes every write-through pulse at once
    always @(posedge clk) begin
        if (rst_n && mem_wr_valid) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (mem_wr_byteen[b]) begin
                    mem_img[mem_wr_addr] = memory_word(mem_wr_addr);
                    mem_img[mem_wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] =
                        mem_wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    initial begin : responder
        int                    latency;
        logic [ADDR_WIDTH-1:0] line_addr;
        forever begin
            @(posedge clk);
            if (rst_n && mem_rd_valid) begin
                line_addr = mem_rd_addr;
                latency   = 1 + ($unsigned($random(seed)) % 8);
                repeat (latency - 1) @(posedge clk);
                #2;
                for (int w = 0; w < LINE_WORDS; w++) begin
                    mem_fill_data[w*WORD_WIDTH +: WORD_WIDTH] =
                        memory_word(line_addr + ADDR_WIDTH'(w * WORD_BYTES));
                end
                mem_fill_valid = 1'b1;
                @(posedge clk);
                #2 mem_fill_valid = 1'b0;
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with requests still outstanding", LIMIT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_op         = OP_READ;
        req_addr       = '0;
        req_byteen     = '0;
        req_data       = '0;
        mem_fill_valid = 1'b0;
        mem_fill_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int n = 0; n < NUM_REQS; n++) begin
            while (busy) begin
                req_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            drive_request();
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
        while (!drained) begin
            @(posedge clk);
            #2;
        end
        $display("Requests %0d, reads %0d, writes %0d, errors %0d",
                 NUM_REQS, reads, writes, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* cache_bank_checker.sv */
`timescale 1ns/1ns

module cache_bank_checker #(
    parameter int NUM_WAYS   = 2,
    parameter int NUM_SETS   = 8,
    parameter int LINE_WORDS = 4,
    parameter int WORD_BYTES = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        req_valid,
    input  cache_pkg::req_op_t                          req_op,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]            req_addr,
    input  logic [WORD_BYTES-1:0]                       req_byteen,
    input  logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0] req_data,
    input  logic                                        busy,
    input  logic                                        rsp_valid,
    input  logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0] rsp_data,
    input  logic                                        mem_rd_valid,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]            mem_rd_addr,
    input  logic                                        mem_wr_valid,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]            mem_wr_addr,
    input  logic [WORD_BYTES-1:0]                       mem_wr_byteen,
    input  logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0] mem_wr_data,
    output int                                          errors,
    output logic                                        drained
);
    import cache_pkg::*;

    localparam int WORD_WIDTH  = WORD_BYTES * BYTE_WIDTH;
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS) + $clog2(WORD_BYTES);
    localparam int LINE_BITS   = ADDR_WIDTH - OFFSET_BITS;
    // A read hit is sampled on the third edge after its acceptance edge
    localparam int HIT_EDGES   = 3;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
        logic                  miss;
        logic                  timed;
        int                    cycle;
    } read_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_BYTES-1:0] byteen;
        logic [WORD_WIDTH-1:0] data;
    } write_t;

    read_t                 read_q[$];
    write_t                write_q[$];
    logic [ADDR_WIDTH-1:0] fetch_q[$];
    logic [WORD_WIDTH-1:0] image [logic [ADDR_WIDTH-1:0]];
    // Residency model holds line addresses per set and way
    logic [LINE_BITS-1:0]  line_addr [NUM_SETS][NUM_WAYS];
    logic                  line_valid [NUM_SETS][NUM_WAYS];
    int                    rr_ptr [NUM_SETS];
    int                    cycle;
    int                    misses_ahead;
    logic                  reset_checked;
    read_t                 rd;
    write_t                wr;
    logic [ADDR_WIDTH-1:0] fetch;

    function automatic logic [WORD_WIDTH-1:0] initial_word(logic [ADDR_WIDTH-1:0] addr);
        return WORD_WIDTH'((addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]});
    endfunction

    function automatic logic [WORD_WIDTH-1:0] image_word(logic [ADDR_WIDTH-1:0] addr);
        if (image.exists(addr)) begin
            return image[addr];
        end
        return initial_word(addr);
    endfunction

    function automatic logic [WORD_WIDTH-1:0] merge_bytes(logic [WORD_WIDTH-1:0] old,
                                                         logic [WORD_BYTES-1:0] be,
                                                         logic [WORD_WIDTH-1:0] data);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                old[b*BYTE_WIDTH +: BYTE_WIDTH] = data[b*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
        return old;
    endfunction

    // Lowest invalid way, else round robin; pointer moves only on a full set
    function automatic logic predict_miss(logic [ADDR_WIDTH-1:0] addr);
        int   set_i;
        int   victim;
        logic hit;
        set_i  = int'(addr[OFFSET_BITS +: SET_BITS]);
        victim = -1;
        hit    = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (line_valid[set_i][w] && line_addr[set_i][w] == addr[ADDR_WIDTH-1:OFFSET_BITS]) begin
                hit = 1'b1;
            end
            if (victim < 0 && !line_valid[set_i][w]) begin
                victim = w;
            end
        end
        if (!hit) begin
            if (victim < 0) begin
                victim        = rr_ptr[set_i];
                rr_ptr[set_i] = (rr_ptr[set_i] + 1) % NUM_WAYS;
            end
            line_valid[set_i][victim] = 1'b1;
            line_addr[set_i][victim]  = addr[ADDR_WIDTH-1:OFFSET_BITS];
        end
        return !hit;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] = 0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    line_valid[s][w] = 1'b0;
                end
            end
            cycle         = 0;
            misses_ahead  = 0;
            errors        = 0;
            reset_checked = 1'b0;
        end else begin
            cycle++;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if ({busy, rsp_valid, mem_rd_valid, mem_wr_valid} !== 4'b0000) begin
                    $display("FAILED %0t: outputs not idle after reset, busy %b rsp %b rd %b wr %b",
                             $time, busy, rsp_valid, mem_rd_valid, mem_wr_valid);
                    errors++;
                end
            end
            // Responses first, so a request on the same edge sees the updated queue
            if (rsp_valid) begin
                if (read_q.size() == 0) begin
                    $display("Read response at %0t with no read outstanding", $time);
                    errors++;
                end else begin
                    rd = read_q.pop_front();
                    if (rd.miss) begin
                        misses_ahead--;
                    end
                    if (rsp_data !== rd.data) begin
                        $display("FAILED %0t: read of %h returned %h, expected %h",
                                 $time, rd.addr, rsp_data, rd.data);
                        errors++;
                    end
                    if (rd.timed && (cycle - rd.cycle != HIT_EDGES)) begin
                        $display("FAILED %0t: read hit of %h took %0d edges, expected %0d",
                                 $time, rd.addr, cycle - rd.cycle, HIT_EDGES);
                        errors++;
                    end
                end
            end
            if (mem_rd_valid) begin
                if (fetch_q.size() == 0) begin
                    $display("Memory read of %h at %0t where no miss was expected",
                             mem_rd_addr, $time);
                    errors++;
                end else begin
                    fetch = fetch_q.pop_front();
                    if (mem_rd_addr !== fetch) begin
                        $display("FAILED %0t: memory read of %h, expected %h",
                                 $time, mem_rd_addr, fetch);
                        errors++;
                    end
                end
            end
            if (mem_wr_valid) begin
                if (write_q.size() == 0) begin
                    $display("Memory write at %0t with no write outstanding", $time);
                    errors++;
                end else begin
                    wr = write_q.pop_front();
                    if ({mem_wr_addr, mem_wr_byteen, mem_wr_data} !== wr) begin
                        $display("FAILED %0t: memory write %h/%h/%h, expected %h/%h/%h",
                                 $time, mem_wr_addr, mem_wr_byteen, mem_wr_data,
                                 wr.addr, wr.byteen, wr.data);
                        errors++;
                    end
                end
            end
            if (req_valid && req_op == OP_READ) begin
                // Write-through keeps the cache equal to the image at acceptance
                rd.addr  = req_addr;
                rd.data  = image_word(req_addr);
                rd.miss  = predict_miss(req_addr);
                rd.timed = !rd.miss && (misses_ahead == 0);
                rd.cycle = cycle;
                if (rd.miss) begin
                    misses_ahead++;
                    fetch_q.push_back({req_addr[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)});
                end
                read_q.push_back(rd);
            end else if (req_valid) begin
                wr.addr   = req_addr;
                wr.byteen = req_byteen;
                wr.data   = req_data;
                write_q.push_back(wr);
                image[req_addr] = merge_bytes(image_word(req_addr), req_byteen, req_data);
            end
        end
        drained = (read_q.size() == 0) && (write_q.size() == 0) && (fetch_q.size() == 0);
    end

endmodule

/* cache_bank.sv */
`timescale 1ns/1ns

module cache_bank #(
    parameter int NUM_WAYS   = 2,
    parameter int NUM_SETS   = 8,
    parameter int LINE_WORDS = 4,
    parameter int WORD_BYTES = 4
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   req_valid,
    input  cache_pkg::req_op_t                                     req_op,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]                       req_addr,
    input  logic [WORD_BYTES-1:0]                                  req_byteen,
    input  logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0]            req_data,
    output logic                                                   busy,
    output logic                                                   rsp_valid,
    output logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0]            rsp_data,
    output logic                                                   mem_rd_valid,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                       mem_rd_addr,
    input  logic                                                   mem_fill_valid,
    input  logic [LINE_WORDS*WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0] mem_fill_data,
    output logic                                                   mem_wr_valid,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                       mem_wr_addr,
    output logic [WORD_BYTES-1:0]                                  mem_wr_byteen,
    output logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0]            mem_wr_data
);
    import cache_pkg::*;

    localparam int WORD_WIDTH  = WORD_BYTES * BYTE_WIDTH;
    localparam int LINE_WIDTH  = LINE_WORDS * WORD_WIDTH;
    localparam int BYTE_BITS   = $clog2(WORD_BYTES);
    localparam int WSEL_BITS   = $clog2(LINE_WORDS);
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = WSEL_BITS + BYTE_BITS;

    bank_state_t state_q;
    bank_state_t state_d;

    // Stage 0 holds the accepted request
    logic                  s0_valid;
    req_op_t               s0_op;
    logic [ADDR_WIDTH-1:0] s0_addr;
    logic [WORD_BYTES-1:0] s0_byteen;
    logic [WORD_WIDTH-1:0] s0_data;

    // Stage 1 does the tag lookup and data access
    logic                  s1_valid;
    req_op_t               s1_op;
    logic [ADDR_WIDTH-1:0] s1_addr;
    logic [WORD_BYTES-1:0] s1_byteen;
    logic [WORD_WIDTH-1:0] s1_data;

    logic [ADDR_WIDTH-1:0] miss_addr;
    logic [LINE_WIDTH-1:0] fill_line;
    logic                  rsp_pending;

    logic                  running;
    logic [ADDR_WIDTH-1:0] lookup_addr;
    logic                  hit;
    logic [NUM_WAYS-1:0]   hit_way;
    logic [NUM_WAYS-1:0]   victim_way;
    logic [NUM_WAYS-1:0]   data_way;
    logic                  s1_read;
    logic                  s1_write;
    logic                  read_miss;
    logic                  data_read;
    logic                  data_write;
    logic                  data_fill;

    assign running  = (state_q == S_RUN);
    assign s1_read  = running && s1_valid && (s1_op == OP_READ);
    assign s1_write = running && s1_valid && (s1_op == OP_WRITE);

    // A missed read leaves stage 1 and is tracked by miss_addr
    assign read_miss   = s1_read && !hit;
    assign lookup_addr = running ? s1_addr : miss_addr;

    assign data_read  = (s1_read && hit) || (state_q == S_REPLAY);
    assign data_write = s1_write && hit;
    assign data_fill  = (state_q == S_FILL);
    assign data_way   = data_fill ? victim_way : hit_way;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_RUN: begin
                if (read_miss) begin
                    state_d = S_MISS_REQ;
                end
            end
            S_MISS_REQ: state_d = S_MISS_WAIT;
            S_MISS_WAIT: begin
                if (mem_fill_valid) begin
                    state_d = S_FILL;
                end
            end
            S_FILL:   state_d = S_REPLAY;
            S_REPLAY: state_d = S_RUN;
            default:  state_d = S_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= S_RUN;
            s0_valid    <= 1'b0;
            s1_valid    <= 1'b0;
            rsp_pending <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_pending <= data_read;
            // Both stages freeze while a miss is serviced
            if (running) begin
                s0_valid <= req_valid;
                s1_valid <= s0_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            if (req_valid) begin
                s0_op     <= req_op;
                s0_addr   <= req_addr;
                s0_byteen <= req_byteen;
                s0_data   <= req_data;
            end
            s1_op     <= s0_op;
            s1_addr   <= s0_addr;
            s1_byteen <= s0_byteen;
            s1_data   <= s0_data;
        end
        if (read_miss) begin
            miss_addr <= s1_addr;
        end
        if ((state_q == S_MISS_WAIT) && mem_fill_valid) begin
            fill_line <= mem_fill_data;
        end
    end

    cache_tags #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_WORDS (LINE_WORDS),
        .WORD_BYTES (WORD_BYTES)
    ) tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill        (data_fill),
        .fill_way    (victim_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    cache_data #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_WORDS (LINE_WORDS),
        .WORD_BYTES (WORD_BYTES)
    ) data (
        .clk        (clk),
        .read       (data_read),
        .write      (data_write),
        .fill       (data_fill),
        .set_idx    (lookup_addr[OFFSET_BITS +: SET_BITS]),
        .wsel       (lookup_addr[BYTE_BITS +: WSEL_BITS]),
        .byteen     (s1_byteen),
        .write_data (s1_data),
        .fill_data  (fill_line),
        .way_sel    (data_way),
        .read_data  (rsp_data)
    );

    assign busy      = !running;
    assign rsp_valid = rsp_pending;

    assign mem_rd_valid = (state_q == S_MISS_REQ);
    assign mem_rd_addr  = {miss_addr[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};

    // Every write goes through, hit or miss
    assign mem_wr_valid  = s1_write;
    assign mem_wr_addr   = s1_addr;
    assign mem_wr_byteen = s1_byteen;
    assign mem_wr_data   = s1_data;

    a_req_not_busy: assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> !busy)
        else $error("Request strobe while busy");

    // The line written in S_FILL must be found by the replay lookup
    a_replay_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == S_FILL) |=> hit)
        else $error("Replay lookup missed after fill");

endmodule

/* cache_data.sv */
`timescale 1ns/1ns

module cache_data #(
    parameter int NUM_WAYS   = 2,
    parameter int NUM_SETS   = 8,
    parameter int LINE_WORDS = 4,
    parameter int WORD_BYTES = 4
) (
    input  logic                                                   clk,
    input  logic                                                   read,
    input  logic                                                   write,
    input  logic                                                   fill,
    input  logic [$clog2(NUM_SETS)-1:0]                            set_idx,
    input  logic [$clog2(LINE_WORDS)-1:0]                          wsel,
    input  logic [WORD_BYTES-1:0]                                  byteen,
    input  logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0]            write_data,
    input  logic [LINE_WORDS*WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0] fill_data,
    input  logic [NUM_WAYS-1:0]                                    way_sel,
    output logic [WORD_BYTES*cache_pkg::BYTE_WIDTH-1:0]            read_data
);
    import cache_pkg::*;

    localparam int WORD_WIDTH = WORD_BYTES * BYTE_WIDTH;
    localparam int WSEL_BITS  = $clog2(LINE_WORDS);
    localparam int WAY_BITS   = idx_bits(NUM_WAYS);
    localparam int ROW_WIDTH  = LINE_WORDS * NUM_WAYS * WORD_WIDTH;
    localparam int ROW_BYTES  = LINE_WORDS * NUM_WAYS * WORD_BYTES;

    // Row layout is word, then way, so the way mux sits last on the read path
    logic [LINE_WORDS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0] row_wdata;
    logic [LINE_WORDS-1:0][NUM_WAYS-1:0][WORD_BYTES-1:0] row_wren;
    logic [LINE_WORDS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0] row_rdata;
    logic [LINE_WORDS-1:0][WORD_WIDTH-1:0]               fill_words;

    logic [WAY_BITS-1:0]  way_idx;
    logic [WAY_BITS-1:0]  way_idx_q;
    logic [WSEL_BITS-1:0] wsel_q;

    assign fill_words = fill_data;

    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            for (int j = 0; j < NUM_WAYS; j++) begin
                if (fill) begin
                    row_wdata[i][j] = fill_words[i];
                    row_wren[i][j]  = {WORD_BYTES{way_sel[j]}};
                end else begin
                    // Word is replicated everywhere and the enables pick one word
                    row_wdata[i][j] = write_data;
                    if (WSEL_BITS'(i) == wsel) begin
                        row_wren[i][j] = byteen & {WORD_BYTES{way_sel[j]}};
                    end else begin
                        row_wren[i][j] = '0;
                    end
                end
            end
        end
    end

    // One-hot to index
    always_comb begin
        way_idx = '0;
        for (int j = 0; j < NUM_WAYS; j++) begin
            if (way_sel[j]) begin
                way_idx = way_idx | WAY_BITS'(j);
            end
        end
    end

    // Selection is held alongside the RAM read
    always_ff @(posedge clk) begin
        if (read) begin
            wsel_q    <= wsel;
            way_idx_q <= way_idx;
        end
    end

    cache_sp_ram #(
        .DATAW (ROW_WIDTH),
        .SIZE  (NUM_SETS),
        .WRENW (ROW_BYTES)
    ) data_store (
        .clk   (clk),
        .write (write || fill),
        .wren  (row_wren),
        .addr  (set_idx),
        .wdata (row_wdata),
        .rdata (row_rdata)
    );

    assign read_data = row_rdata[wsel_q][way_idx_q];

    // The miss controller keeps fills and write hits in separate cycles
    a_fill_write_excl: assert property (@(posedge clk) write |-> !fill)
        else $error("Fill and write in the same cycle");

endmodule

/* cache_tags.sv */
`timescale 1ns/1ns

module cache_tags #(
    parameter int NUM_WAYS   = 2,
    parameter int NUM_SETS   = 8,
    parameter int LINE_WORDS = 4,
    parameter int WORD_BYTES = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cache_pkg::ADDR_WIDTH-1:0] lookup_addr,
    input  logic                             fill,
    input  logic [NUM_WAYS-1:0]              fill_way,
    output logic                             hit,
    output logic [NUM_WAYS-1:0]              hit_way,
    output logic [NUM_WAYS-1:0]              victim_way
);
    import cache_pkg::*;

    localparam int BYTE_BITS = $clog2(WORD_BYTES);
    localparam int WSEL_BITS = $clog2(LINE_WORDS);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS  = ADDR_WIDTH - SET_BITS - WSEL_BITS - BYTE_BITS;
    localparam int WAY_BITS  = idx_bits(NUM_WAYS);

    logic [TAG_BITS-1:0]                 tag_q [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]   valid_q;
    // Round-robin replacement pointer per set
    logic [NUM_SETS-1:0][WAY_BITS-1:0]   rr_q;

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] lookup_tag;
    logic [NUM_WAYS-1:0] set_valid;
    logic                set_full;

    assign set_idx    = lookup_addr[BYTE_BITS + WSEL_BITS +: SET_BITS];
    assign lookup_tag = lookup_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign set_valid  = valid_q[set_idx];
    assign set_full   = &set_valid;

    // Compare all ways of the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = set_valid[w] && (tag_q[w][set_idx] == lookup_tag);
        end
    end

    assign hit = |hit_way;

    // Lowest invalid way first, else the set's round-robin way
    always_comb begin
        logic found;
        found      = 1'b0;
        victim_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !set_valid[w]) begin
                victim_way[w] = 1'b1;
                found         = 1'b1;
            end
        end
        if (!found) begin
            victim_way[rr_q[set_idx]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (fill) begin
            valid_q[set_idx] <= set_valid | fill_way;
            // Pointer moves only when a full set loses a line
            if (set_full) begin
                if (rr_q[set_idx] == WAY_BITS'(NUM_WAYS - 1)) begin
                    rr_q[set_idx] <= '0;
                end else begin
                    rr_q[set_idx] <= rr_q[set_idx] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way[w]) begin
                    tag_q[w][set_idx] <= lookup_tag;
                end
            end
        end
    end

    // Fills never leave two ways holding the same line
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_way))
        else $error("Lookup hit in more than one way: %b", hit_way);

endmodule

/* cache_sp_ram.sv */
`timescale 1ns/1ns

module cache_sp_ram #(
    parameter int DATAW = 64,
    parameter int SIZE  = 16,
    parameter int WRENW = 8
) (
    input  logic                    clk,
    input  logic                    write,
    input  logic [WRENW-1:0]        wren,
    input  logic [$clog2(SIZE)-1:0] addr,
    input  logic [DATAW-1:0]        wdata,
    output logic [DATAW-1:0]        rdata
);
    import cache_pkg::*;

    // One enable per byte lane
    localparam int SEGW = BYTE_WIDTH;

    logic [DATAW-1:0] mem [SIZE];

    // Read every cycle; a same-address write returns the old row
    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < WRENW; i++) begin
                if (wren[i]) begin
                    mem[addr][i*SEGW +: SEGW] <= wdata[i*SEGW +: SEGW];
                end
            end
        end
        rdata <= mem[addr];
    end

    a_addr_range: assert property (@(posedge clk) write |-> (addr < SIZE))
        else $error("RAM write outside storage at address %0d", addr);

endmodule

/* cache_pkg.sv */
package cache_pkg;

    // Byte address width seen by the core and by memory
    localparam int ADDR_WIDTH = 32;

    // Bits per byte lane in data and enable vectors
    localparam int BYTE_WIDTH = 8;

    // Operation carried in each pipeline stage
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_t;

    // Miss controller states
    typedef enum logic [2:0] {
        S_RUN       = 3'd0,
        S_MISS_REQ  = 3'd1,
        S_MISS_WAIT = 3'd2,
        S_FILL      = 3'd3,
        S_REPLAY    = 3'd4
    } bank_state_t;

    // Index width for n items, never less than one bit
    function automatic int idx_bits(int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

endpackage
